// File: logic/motor_pkg.sv
/* Shared widths, register map and timing for the drive motor subsystem.
   FIFO_DEPTH and MOTOR_COUNT are assumed to be powers of two. */
`default_nettype none

package motor_pkg;

    ////////////////////
    // Sizes and timing
    ////////////////////
    localparam int MOTOR_COUNT      = 4;        // Drive motors
    localparam int FIFO_DEPTH       = 4;        // Update items in flight
    localparam int CMD_CREDITS      = FIFO_DEPTH; // Host credits after reset
    localparam int PRESCALE         = 64;       // Clocks per PWM tick
    localparam int PWM_PERIOD_TICKS = 256;      // Ticks per PWM period

    ////////////////////
    // Vector types
    ////////////////////
    typedef logic [5:0] addr_t;                 // Register address
    typedef logic [7:0] data_t;                 // Write data byte
    typedef logic [4:0] duty_t;                 // Drive duty code
    typedef logic [7:0] ratio_t;                // High time out of 256 ticks
    typedef logic [3:0] level_t;                // LED brightness
    typedef logic [1:0] credit_t;               // Credits back per cycle, 0 to 2
    typedef logic [$clog2(MOTOR_COUNT)-1:0]  motor_index_t;
    typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_t;  // Holds 0 to FIFO_DEPTH
    typedef logic [$clog2(PRESCALE)-1:0]     prescale_t;

    typedef enum logic [1:0] {
        KIND_MOTOR,                             // Motor enable, direction, duty
        KIND_LED_LEVEL,                         // LED brightness
        KIND_LED_FLAGS                          // Fault, pi, ps4 flags
    } update_kind_t;

    ////////////////////
    // Register map
    ////////////////////
    localparam addr_t ADDR_MOTOR_BASE = 6'd0;   // Motor n at base + n
    localparam addr_t ADDR_LED_LEVEL  = 6'd4;
    localparam addr_t ADDR_LED_FLAGS  = 6'd5;

    // Motor write fields, duty code in bits 4:0
    localparam int MOTOR_ENABLE_BIT = 6;
    localparam int MOTOR_DIR_BIT    = 5;

    // LED flag write fields
    localparam int LED_FAULT_BIT = 0;
    localparam int LED_PI_BIT    = 1;
    localparam int LED_PS4_BIT   = 2;

endpackage

`default_nettype wire

// File: logic/cmd_decoder.sv
/* Host writes are taken only while the host holds a credit, so there is no ready.
   Unmapped addresses are dropped and still cost exactly one credit. */
`default_nettype none

module cmd_decoder import motor_pkg::*; (
    input  logic         clock,
    input  logic         reset_n,
    input  logic         cmd_valid,     // One write per credit
    input  addr_t        cmd_address,
    input  data_t        cmd_data,
    output logic         push,          // Mapped write, one cycle later
    output update_kind_t push_kind,
    output motor_index_t push_index,
    output data_t        push_data,
    output logic         drop           // Unmapped write, credit only
);

    addr_t        motor_offset;
    logic         mapped;
    update_kind_t kind;

    assign motor_offset = cmd_address - ADDR_MOTOR_BASE;   // Wraps high below base

    ////////////////////
    // Address decode
    ////////////////////
    always_comb begin
        mapped = 1'b1;
        kind   = KIND_MOTOR;
        if (motor_offset < addr_t'(MOTOR_COUNT)) begin
            kind = KIND_MOTOR;                  // Motor block
        end else if (cmd_address == ADDR_LED_LEVEL) begin
            kind = KIND_LED_LEVEL;
        end else if (cmd_address == ADDR_LED_FLAGS) begin
            kind = KIND_LED_FLAGS;
        end else begin
            mapped = 1'b0;                      // Hole in the map
        end
    end

    ////////////////////
    // Output register
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            push <= 1'b0;
            drop <= 1'b0;
        end else begin
            push <= cmd_valid & mapped;
            drop <= cmd_valid & ~mapped;        // Single cycle pulse
        end
    end

    // Item fields, only meaningful with push
    always_ff @(posedge clock) begin
        if (cmd_valid) begin
            push_kind  <= kind;
            push_index <= motor_index_t'(motor_offset);    // Ignored for LED items
            push_data  <= cmd_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/update_fifo.sv
/* No full flag: the credit count keeps pushes within FIFO_DEPTH.
   Pop must only come with not_empty. Head fields are read straight from storage. */
`default_nettype none

module update_fifo import motor_pkg::*; (
    input  logic         clock,
    input  logic         reset_n,
    input  logic         push,
    input  update_kind_t push_kind,
    input  motor_index_t push_index,
    input  data_t        push_data,
    input  logic         drop,          // Unmapped write from decoder
    input  logic         pop,
    output logic         not_empty,
    output update_kind_t head_kind,
    output motor_index_t head_index,
    output data_t        head_data,
    output credit_t      cmd_credits    // Credits back to host this cycle
);

    update_kind_t kind_mem  [FIFO_DEPTH];
    motor_index_t index_mem [FIFO_DEPTH];
    data_t        data_mem  [FIFO_DEPTH];
    fifo_ptr_t    wr_ptr;
    fifo_ptr_t    rd_ptr;
    fifo_count_t  count;

    function automatic fifo_ptr_t ptr_next(input fifo_ptr_t ptr);
        if (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////
    // Storage
    ////////////////////
    always_ff @(posedge clock) begin
        if (push) begin
            kind_mem[wr_ptr]  <= push_kind;
            index_mem[wr_ptr] <= push_index;
            data_mem[wr_ptr]  <= push_data;
        end
    end

    assign head_kind  = kind_mem[rd_ptr];
    assign head_index = index_mem[rd_ptr];
    assign head_data  = data_mem[rd_ptr];
    assign not_empty  = (count != '0);

    ////////////////////
    // Pointers, occupancy and credits
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            cmd_credits <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
            cmd_credits <= credit_t'(drop) + credit_t'(pop);   // Each write ends here
        end
    end

endmodule

`default_nettype wire

// File: logic/pwm_bank.sv
/* One item is applied per prescale tick, so the FIFO drains at one per PRESCALE clocks.
   New duty and brightness reach the waveform at the next period start only. */
`default_nettype none

module pwm_bank import motor_pkg::*; (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   not_empty,
    input  update_kind_t           head_kind,
    input  motor_index_t           head_index,
    input  data_t                  head_data,
    output logic                   pop,
    output logic [MOTOR_COUNT-1:0] drive_pwm,
    output logic [MOTOR_COUNT-1:0] drive_dir,
    output logic                   status_fault,
    output logic                   status_pi,
    output logic                   status_ps4,
    output logic                   status_debug
);

    prescale_t              prescale_count;
    logic                   tick;           // One clock per PRESCALE
    ratio_t                 period_count;
    logic                   period_end;     // Counter wraps to 0 next edge
    logic [MOTOR_COUNT-1:0] motor_enable;
    logic [MOTOR_COUNT-1:0] motor_dir;
    duty_t                  motor_duty  [MOTOR_COUNT];
    ratio_t                 motor_ratio [MOTOR_COUNT];  // Active this period
    level_t                 led_level;
    ratio_t                 led_ratio;
    logic                   flag_fault;
    logic                   flag_pi;
    logic                   flag_ps4;
    logic                   led_wave;

    ////////////////////
    // Timebase
    ////////////////////
    assign tick       = (prescale_count == prescale_t'(PRESCALE - 1));
    assign period_end = tick && (period_count == ratio_t'(PWM_PERIOD_TICKS - 1));
    assign pop        = tick & not_empty;   // At most one item per tick

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            prescale_count <= '0;
            period_count   <= '0;
        end else begin
            prescale_count <= tick ? '0 : prescale_count + 1'b1;
            if (tick) begin
                period_count <= period_end ? '0 : period_count + 1'b1;
            end
        end
    end

    ////////////////////
    // Register file
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            motor_enable <= '0;
            motor_dir    <= '0;
            for (int n = 0; n < MOTOR_COUNT; n++) begin
                motor_duty[n] <= '0;
            end
            led_level  <= '0;
            flag_fault <= 1'b0;
            flag_pi    <= 1'b0;
            flag_ps4   <= 1'b0;
        end else if (pop) begin
            case (head_kind)
                KIND_MOTOR: begin
                    motor_enable[head_index] <= head_data[MOTOR_ENABLE_BIT];
                    motor_dir[head_index]    <= head_data[MOTOR_DIR_BIT];
                    motor_duty[head_index]   <= head_data[$bits(duty_t)-1:0];
                end
                KIND_LED_LEVEL: begin
                    led_level <= head_data[$bits(level_t)-1:0];    // Upper nibble unused
                end
                KIND_LED_FLAGS: begin
                    flag_fault <= head_data[LED_FAULT_BIT];
                    flag_pi    <= head_data[LED_PI_BIT];
                    flag_ps4   <= head_data[LED_PS4_BIT];
                end
                default: ;                      // Unused encoding
            endcase
        end
    end

    // Active ratios load as the period counter wraps to 0
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int n = 0; n < MOTOR_COUNT; n++) begin
                motor_ratio[n] <= '0;
            end
            led_ratio <= '0;
        end else if (period_end) begin
            for (int n = 0; n < MOTOR_COUNT; n++) begin
                motor_ratio[n] <= {1'b0, motor_duty[n], 2'b00};   // At most 124
            end
            led_ratio <= {led_level, 4'b0000};
        end
    end

    ////////////////////
    // Outputs
    ////////////////////
    always_comb begin
        for (int n = 0; n < MOTOR_COUNT; n++) begin
            drive_pwm[n] = motor_enable[n] && (period_count < motor_ratio[n]);
        end
    end

    assign drive_dir    = motor_dir;                // Direction acts at once
    assign led_wave     = (period_count < led_ratio);
    assign status_fault = led_wave & flag_fault;
    assign status_pi    = led_wave & flag_pi;
    assign status_ps4   = led_wave & flag_ps4;
    assign status_debug = led_wave;                 // Bare brightness wave

endmodule

`default_nettype wire

// File: logic/motor_subsystem.sv
/* Host starts with CMD_CREDITS credits and sends one write per credit held.
   reset_n is asynchronous and comes from outside. */
`default_nettype none

module motor_subsystem import motor_pkg::*; (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   cmd_valid,
    input  addr_t                  cmd_address,
    input  data_t                  cmd_data,
    output credit_t                cmd_credits,
    output logic [MOTOR_COUNT-1:0] drive_pwm,
    output logic [MOTOR_COUNT-1:0] drive_dir,
    output logic                   status_fault,
    output logic                   status_pi,
    output logic                   status_ps4,
    output logic                   status_debug
);

    logic         push;             // Decoder to FIFO
    update_kind_t push_kind;
    motor_index_t push_index;
    data_t        push_data;
    logic         drop;
    logic         not_empty;        // FIFO to bank
    update_kind_t head_kind;
    motor_index_t head_index;
    data_t        head_data;
    logic         pop;

    ////////////////////
    // Write path
    ////////////////////
    cmd_decoder decoder_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .cmd_valid   (cmd_valid),
        .cmd_address (cmd_address),
        .cmd_data    (cmd_data),
        .push        (push),
        .push_kind   (push_kind),
        .push_index  (push_index),
        .push_data   (push_data),
        .drop        (drop)
    );

    update_fifo fifo_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .push        (push),
        .push_kind   (push_kind),
        .push_index  (push_index),
        .push_data   (push_data),
        .drop        (drop),
        .pop         (pop),
        .not_empty   (not_empty),
        .head_kind   (head_kind),
        .head_index  (head_index),
        .head_data   (head_data),
        .cmd_credits (cmd_credits)
    );

    ////////////////////
    // Drive side
    ////////////////////
    pwm_bank bank_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .not_empty    (not_empty),
        .head_kind    (head_kind),
        .head_index   (head_index),
        .head_data    (head_data),
        .pop          (pop),
        .drive_pwm    (drive_pwm),
        .drive_dir    (drive_dir),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
/* 4 ns clock from time 0. reset_n drops at 1 ns and is held low for 5 rising edges */
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;          // 4 ns period
    end

    initial begin
        reset_n = 1'b1;
        #1 reset_n = 1'b0;                  // Clean falling edge before first clock
        repeat (5) @(posedge clock);
        reset_n <= 1'b1;                    // Released on a rising edge
    end

endmodule

`default_nettype wire

// File: verification/motor_subsystem_asserts.sv
/* Bound into motor_subsystem. FIFO occupancy is taken from fifo_i by hierarchical name.
   Failures are also counted in assert_errors for the testbench summary */
`default_nettype none

module motor_subsystem_asserts import motor_pkg::*; (
    input logic                   clock,
    input logic                   reset_n,
    input logic                   push,
    input logic                   pop,
    input fifo_count_t            fifo_count,
    input credit_t                cmd_credits,
    input logic [MOTOR_COUNT-1:0] drive_pwm,
    input logic [MOTOR_COUNT-1:0] drive_dir,
    input logic                   status_fault,
    input logic                   status_pi,
    input logic                   status_ps4,
    input logic                   status_debug
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_errors = 0;                  // Read by the testbench at the end

    ////////////////////
    // FIFO and credits
    ////////////////////
    push_not_full: assert property (@(posedge clock) disable iff (!reset_n)
        push |-> (fifo_count < fifo_count_t'(FIFO_DEPTH)))
        else begin
            assert_errors++;
            $error("push into a full update FIFO");
        end

    // Pop checked against the FIFO's own occupancy
    pop_not_empty: assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> (fifo_count != '0))
        else begin
            assert_errors++;
            $error("pop from an empty update FIFO");
        end

    credits_bounded: assert property (@(posedge clock) disable iff (!reset_n)
        cmd_credits <= credit_t'(2))
        else begin
            assert_errors++;
            $error("cmd_credits above 2 in one cycle");
        end

    // Outputs held low while reset_n is asserted
    quiet_in_reset: assert property (@(posedge clock)
        !reset_n |-> (drive_pwm == '0 && drive_dir == '0 && !status_fault
                      && !status_pi && !status_ps4 && !status_debug))
        else begin
            assert_errors++;
            $error("outputs not low while reset_n is asserted");
        end

endmodule

bind motor_subsystem motor_subsystem_asserts asserts_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .push         (push),
    .pop          (pop),
    .fifo_count   (fifo_i.count),
    .cmd_credits  (cmd_credits),
    .drive_pwm    (drive_pwm),
    .drive_dir    (drive_dir),
    .status_fault (status_fault),
    .status_pi    (status_pi),
    .status_ps4   (status_ps4),
    .status_debug (status_debug)
);

`default_nettype wire

// File: verification/motor_subsystem_tb.sv
/* Waveforms are measured over one whole PWM period after all credits are back,
   so any 256*PRESCALE clock window gives the high time. Seed 89 fixes the stimulus */
`default_nettype none

module motor_subsystem_tb import motor_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD_CLOCKS    = PRESCALE * PWM_PERIOD_TICKS;
    localparam int TIMEOUT_CYCLES   = 12 * PERIOD_CLOCKS + 1000;
    localparam int ROUNDS           = 3;
    localparam int WRITES_PER_ROUND = 24;

    logic                   clock;
    logic                   reset_n;
    logic                   cmd_valid;
    addr_t                  cmd_address;
    data_t                  cmd_data;
    credit_t                cmd_credits;
    logic [MOTOR_COUNT-1:0] drive_pwm;
    logic [MOTOR_COUNT-1:0] drive_dir;
    logic                   status_fault;
    logic                   status_pi;
    logic                   status_ps4;
    logic                   status_debug;

    int issued      = 0;                    // Writes sent
    int returned    = 0;                    // Credits seen on cmd_credits
    int cycle_count = 0;
    int errors      = 0;
    int checks      = 0;
    int tests       = 0;
    int unmapped    = 0;
    int pwm_high [MOTOR_COUNT];             // Clocks high in one period
    int led_high [4];                       // Debug, fault, pi, ps4

    // Register model
    logic   model_enable [MOTOR_COUNT];
    logic   model_dir    [MOTOR_COUNT];
    duty_t  model_duty   [MOTOR_COUNT];
    level_t model_level;
    logic   model_fault;
    logic   model_pi;
    logic   model_ps4;

    clock_gen clock_gen_i (
        .clock   (clock),
        .reset_n (reset_n)
    );

    motor_subsystem dut_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .cmd_valid    (cmd_valid),
        .cmd_address  (cmd_address),
        .cmd_data     (cmd_data),
        .cmd_credits  (cmd_credits),
        .drive_pwm    (drive_pwm),
        .drive_dir    (drive_dir),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

    // Credit return and run limit
    always @(posedge clock) begin
        returned    <= returned + int'(cmd_credits);
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////
    // Model
    ////////////////////
    function automatic void apply_write(input addr_t address, input data_t data);
        int n;
        n = int'(address) - int'(ADDR_MOTOR_BASE);
        if (n >= 0 && n < MOTOR_COUNT) begin
            model_enable[n] = data[MOTOR_ENABLE_BIT];
            model_dir[n]    = data[MOTOR_DIR_BIT];
            model_duty[n]   = data[4:0];            // Bit 7 ignored
        end else if (address == ADDR_LED_LEVEL) begin
            model_level = data[3:0];
        end else if (address == ADDR_LED_FLAGS) begin
            model_fault = data[0];
            model_pi    = data[1];
            model_ps4   = data[2];
        end else begin
            unmapped++;                             // Credit only
        end
    endfunction

    function automatic ratio_t motor_ratio(input int n);
        if (!model_enable[n]) begin
            return '0;
        end
        return ratio_t'(model_duty[n]) << 2;        // 5-bit code into 8-bit ratio
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_ratio(input string name, input int high_clocks, input ratio_t expected);
        int want;
        want = int'(expected) * PRESCALE;
        checks++;
        if (high_clocks != want) begin
            errors++;
            $display("MISMATCH at %0t: %s high for %0d clocks, expected %0d (ratio %0d)",
                     $time, name, high_clocks, want, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_credit(input string name, input int total, input int expected);
        checks++;
        if (total != expected) begin
            errors++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, total, expected);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail with %0d errors", name, errors - errors_before);
        end
    endtask

    ////////////////////
    // Stimulus and measurement
    ////////////////////
    task automatic send_burst(input int count);
        int    sent;
        addr_t address;
        data_t data;
        sent = 0;
        while (sent < count) begin
            @(posedge clock);
            if (issued - returned < CMD_CREDITS && $urandom_range(0, 3) != 0) begin
                // Half the writes aim at the register map, the rest anywhere
                address = ($urandom_range(0, 1) == 1) ? addr_t'($urandom_range(0, 5))
                                                      : addr_t'($urandom_range(0, 63));
                data = data_t'($urandom);
                cmd_valid   <= 1'b1;
                cmd_address <= address;
                cmd_data    <= data;
                apply_write(address, data);
                issued++;
                sent++;
            end else begin
                cmd_valid <= 1'b0;                  // Stalled or idle gap
            end
        end
        @(posedge clock);
        cmd_valid <= 1'b0;
    endtask

    task automatic measure_period();
        for (int n = 0; n < MOTOR_COUNT; n++) begin
            pwm_high[n] = 0;
        end
        led_high = '{default: 0};
        repeat (PERIOD_CLOCKS) begin
            @(posedge clock);
            for (int n = 0; n < MOTOR_COUNT; n++) begin
                pwm_high[n] += int'(drive_pwm[n]);
            end
            led_high[0] += int'(status_debug);
            led_high[1] += int'(status_fault);
            led_high[2] += int'(status_pi);
            led_high[3] += int'(status_ps4);
        end
    endtask

    task automatic run_round(input int round);
        int     mark;
        ratio_t led_want;
        mark = errors;
        send_burst(WRITES_PER_ROUND);
        while (returned < issued) @(posedge clock);
        repeat (PERIOD_CLOCKS) @(posedge clock);   // New ratios load at a period start
        check_credit("credits returned", returned, issued);
        end_test($sformatf("round %0d credits", round), mark);

        measure_period();
        mark = errors;
        for (int n = 0; n < MOTOR_COUNT; n++) begin
            check_ratio($sformatf("drive_pwm[%0d]", n), pwm_high[n], motor_ratio(n));
        end
        end_test($sformatf("round %0d duty", round), mark);

        mark = errors;
        for (int n = 0; n < MOTOR_COUNT; n++) begin
            check_bit($sformatf("drive_dir[%0d]", n), drive_dir[n], model_dir[n]);
        end
        end_test($sformatf("round %0d direction", round), mark);

        mark = errors;
        led_want = ratio_t'(model_level) << 4;
        check_ratio("status_debug", led_high[0], led_want);
        check_ratio("status_fault", led_high[1], model_fault ? led_want : ratio_t'(0));
        check_ratio("status_pi", led_high[2], model_pi ? led_want : ratio_t'(0));
        check_ratio("status_ps4", led_high[3], model_ps4 ? led_want : ratio_t'(0));
        end_test($sformatf("round %0d status leds", round), mark);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        int mark;
        int seen;
        void'($urandom(89));
        cmd_valid   = 1'b0;
        cmd_address = '0;
        cmd_data    = '0;
        for (int n = 0; n < MOTOR_COUNT; n++) begin
            model_enable[n] = 1'b0;
            model_dir[n]    = 1'b0;
            model_duty[n]   = '0;
        end
        model_level = '0;
        model_fault = 1'b0;
        model_pi    = 1'b0;
        model_ps4   = 1'b0;

        wait (reset_n === 1'b0);
        wait (reset_n === 1'b1);
        mark = errors;
        seen = 0;
        repeat (20) begin
            @(posedge clock);
            seen += int'(cmd_credits);              // Nothing sent yet
        end
        check_credit("credits before first write", seen, 0);
        for (int n = 0; n < MOTOR_COUNT; n++) begin
            check_bit($sformatf("drive_pwm[%0d]", n), drive_pwm[n], 1'b0);
            check_bit($sformatf("drive_dir[%0d]", n), drive_dir[n], 1'b0);
        end
        check_bit("status_fault", status_fault, 1'b0);
        check_bit("status_pi", status_pi, 1'b0);
        check_bit("status_ps4", status_ps4, 1'b0);
        check_bit("status_debug", status_debug, 1'b0);
        end_test("reset state", mark);

        for (int r = 0; r < ROUNDS; r++) begin
            run_round(r);
        end
        if (unmapped == 0) begin
            errors++;
            $display("No write went to an unmapped address, drop path not exercised");
        end

        errors += dut_i.asserts_i.assert_errors;    // Concurrent assertion failures
        $display("summary: %0d tests, %0d checks, %0d writes, %0d unmapped, %0d errors",
                 tests, checks, issued, unmapped, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: motor_subsystem.f
logic/motor_pkg.sv
logic/cmd_decoder.sv
logic/update_fifo.sv
logic/pwm_bank.sv
logic/motor_subsystem.sv
verification/clock_gen.sv
verification/motor_subsystem_asserts.sv
verification/motor_subsystem_tb.sv

// File: Bender.yml
package:
  name: motor_subsystem

sources:
  # Design
  - logic/motor_pkg.sv
  - logic/cmd_decoder.sv
  - logic/update_fifo.sv
  - logic/pwm_bank.sv
  - logic/motor_subsystem.sv
  # Testbench
  - target: simulation
    files:
      - verification/clock_gen.sv
      - verification/motor_subsystem_asserts.sv
      - verification/motor_subsystem_tb.sv
